// ==== files.f ====
logic/cache_pkg.sv
logic/cache_ifs.sv
logic/cache_wb_slave.sv
logic/cache_pipe.sv
logic/cache_arrays.sv
logic/cache_fm_queue.sv
logic/cache_fm_master.sv
logic/cache_top.sv
dv/cache_props.sv
dv/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache

sources:
  - files:
      - logic/cache_pkg.sv
      - logic/cache_ifs.sv
      - logic/cache_wb_slave.sv
      - logic/cache_pipe.sv
      - logic/cache_arrays.sv
      - logic/cache_fm_queue.sv
      - logic/cache_fm_master.sv
      - logic/cache_top.sv
  - target: test
    files:
      - dv/cache_props.sv
      - dv/cache_tb.sv

// ==== dv/cache_tb.sv ====
//====================================================================
// Cache testbench
//   - clock, reset, xorshift stimulus on the Wishbone slave port
//   - far-memory responder with sparse memory and random ack delay
//   - reference model of memory, tags, valid bits and victim pointers
//   - latency, data and far-memory traffic checks, watchdog
//====================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_tb import cache_pkg::*; ();

    // Matches the DUT defaults
    localparam int MODEL_WAYS  = 4;
    localparam int Q_DEPTH     = 4;
    localparam int NUM_TXN     = 600;
    localparam int MAX_DELAY   = 5;
    localparam int PIPE_LAT    = 5;
    localparam int CLK_PERIOD  = 20;
    // One far-memory op costs at most idle, detect, delay and ack cycles
    localparam int WORST_CYC   = (Q_DEPTH + 1) * (MAX_DELAY + 4) + PIPE_LAT;
    localparam longint WATCHDOG_NS = longint'(NUM_TXN + 20) * WORST_CYC * CLK_PERIOD;
    localparam logic [31:0] SEED     = 32'h4c6f;
    localparam logic [31:0] INIT_XOR = 32'h5a3c_96e1;

    logic              clk;
    logic              reset;
    logic              wb_cyc, wb_stb, wb_we, wb_ack;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_w, wb_dat_r;
    logic              fm_cyc, fm_stb, fm_we, fm_ack;
    logic [ADDR_W-1:0] fm_adr;
    logic [DATA_W-1:0] fm_dat_w, fm_dat_r;

    // Reference model state
    logic [DATA_W-1:0]     model_mem [logic [ADDR_W-1:0]];
    logic [TAG_W-1:0]      m_tag     [NUM_SETS][MODEL_WAYS];
    logic [MODEL_WAYS-1:0] m_valid   [NUM_SETS];
    int                    m_rr      [NUM_SETS];
    // Far-memory side
    logic [DATA_W-1:0]     fm_mem    [logic [ADDR_W-1:0]];
    t_fm_req               exp_fm[$];
    int                    fm_issued;
    int                    fm_done;
    int                    fm_wait;
    logic                  slow_acks;
    logic [31:0]           stim_rng;
    logic [31:0]           ack_rng;

    cache_top dut0 (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .fm_cyc, .fm_stb, .fm_we, .fm_adr, .fm_dat_w, .fm_dat_r, .fm_ack
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //================================================================
    // Helpers
    //================================================================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Untouched memory reads back its address XOR a constant
    function automatic logic [DATA_W-1:0] init_word(input logic [ADDR_W-1:0] a);
        return {{(DATA_W - ADDR_W){1'b0}}, a} ^ INIT_XOR;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic model_hit(input t_cache_addr ca);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < MODEL_WAYS; w++) begin
            if (m_valid[ca.f.set][w] && m_tag[ca.f.set][w] == ca.f.tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Lowest invalid way, else round-robin pointer which then moves on
    task automatic model_install(input t_cache_addr ca);
        int victim;
        victim = -1;
        for (int w = MODEL_WAYS - 1; w >= 0; w--) begin
            if (!m_valid[ca.f.set][w]) begin
                victim = w;
            end
        end
        if (victim < 0) begin
            victim = m_rr[ca.f.set];
            m_rr[ca.f.set] = (m_rr[ca.f.set] + 1) % MODEL_WAYS;
        end
        m_tag[ca.f.set][victim]   = ca.f.tag;
        m_valid[ca.f.set][victim] = 1'b1;
    endtask

    // Bound bus checks, stop as soon as one has fired
    always @(posedge clk) begin
        assert (dut0.props0.error_count == 0)
            else report_failure("A bus protocol assertion failed");
    end

    //================================================================
    // Far-memory responder
    //================================================================
    always @(posedge clk) begin
        t_fm_req exp;
        if (reset) begin
            fm_ack  <= 1'b0;
            fm_wait <= -1;
        end else if (fm_ack) begin
            fm_ack <= 1'b0;
        end else if (fm_cyc && fm_stb) begin
            if (fm_wait < 0) begin
                ack_rng = xorshift(ack_rng);
                fm_wait <= slow_acks ? 4 + int'(ack_rng % 2)
                                     : int'(ack_rng % (MAX_DELAY + 1));
            end else if (fm_wait > 0) begin
                fm_wait <= fm_wait - 1;
            end else begin
                assert (exp_fm.size() > 0)
                    else report_failure("Far-memory cycle seen with no request outstanding");
                exp = exp_fm.pop_front();
                assert (fm_we == (exp.op == FM_WRITE) && fm_adr == exp.addr.raw)
                    else report_failure($sformatf(
                        {"MISMATCH at %0t: far-memory we=%0b adr=0x%04h, ",
                         "expected we=%0b adr=0x%04h"},
                        $time, fm_we, fm_adr, exp.op == FM_WRITE, exp.addr.raw));
                if (fm_we) begin
                    assert (fm_dat_w == exp.data)
                        else report_failure($sformatf(
                            "MISMATCH at %0t: far-memory write data 0x%08h, expected 0x%08h",
                            $time, fm_dat_w, exp.data));
                    fm_mem[fm_adr] = fm_dat_w;
                end else begin
                    fm_dat_r <= fm_mem.exists(fm_adr) ? fm_mem[fm_adr] : init_word(fm_adr);
                end
                fm_ack  <= 1'b1;
                fm_wait <= -1;
                fm_done <= fm_done + 1;
            end
        end
    end

    //================================================================
    // One slave transaction, called right after a rising edge
    //================================================================
    task automatic run_transaction(input logic we, input t_cache_addr ca,
                                   input logic [DATA_W-1:0] data);
        logic              hit;
        logic              room;
        logic [DATA_W-1:0] expected;
        int                lat;
        hit  = model_hit(ca);
        room = (fm_issued - fm_done) < Q_DEPTH;
        if (we || !hit) begin
            exp_fm.push_back('{op: (we ? FM_WRITE : FM_FILL), addr: ca, data: data});
            fm_issued++;
        end
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= ca.raw;
        wb_dat_w <= data;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!wb_ack);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        // Ack went high one edge before it was sampled
        lat = lat - 1;
        if ((!we && hit) || (we && room)) begin
            assert (lat == PIPE_LAT)
                else report_failure($sformatf(
                    "MISMATCH at %0t: ack after %0d cycles, expected %0d",
                    $time, lat, PIPE_LAT));
        end else begin
            assert (lat >= PIPE_LAT)
                else report_failure($sformatf(
                    "MISMATCH at %0t: ack after %0d cycles, below %0d",
                    $time, lat, PIPE_LAT));
        end
        if (we) begin
            model_mem[ca.raw] = data;
        end else begin
            expected = model_mem.exists(ca.raw) ? model_mem[ca.raw] : init_word(ca.raw);
            assert (wb_dat_r == expected)
                else report_failure($sformatf(
                    "MISMATCH at %0t: read 0x%04h gave 0x%08h, expected 0x%08h",
                    $time, ca.raw, wb_dat_r, expected));
            if (!hit) begin
                assert (exp_fm.size() == 0)
                    else report_failure("Read miss completed before its fill reached far memory");
                model_install(ca);
            end
        end
    endtask

    //================================================================
    // Main sequence
    //================================================================
    initial begin : main
        logic [31:0] r;
        logic        we;
        t_cache_addr ca;
        logic [DATA_W-1:0] data;
        reset     = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        fm_ack    = 1'b0;
        fm_dat_r  = '0;
        slow_acks = 1'b0;
        fm_issued = 0;
        fm_done   = 0;
        stim_rng  = SEED;
        // Ack delays come from their own stream
        ack_rng   = ~SEED;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_valid[s] = '0;
            m_rr[s]    = 0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (wb_ack === 1'b0 && fm_cyc === 1'b0)
            else report_failure("wb_ack or fm_cyc not low after reset");

        for (int i = 0; i < NUM_TXN; i++) begin
            // Second half, mostly writes against long acks, fills the queue
            if (i == NUM_TXN / 2) begin
                slow_acks <= 1'b1;
            end
            stim_rng = xorshift(stim_rng);
            r = stim_rng;
            we = (i < NUM_TXN / 2) ? r[31] : (r[31:29] != 3'd0);
            // Six tags over eight sets, so ways conflict
            ca.f.tag = TAG_W'(r[7:0] % 6);
            ca.f.set = SET_W'(r[10:8]);
            stim_rng = xorshift(stim_rng);
            data = stim_rng;
            @(posedge clk);
            run_transaction(we, ca, data);
        end

        // Drain write-through traffic, then the bus must go quiet
        while (exp_fm.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        assert (fm_cyc === 1'b0)
            else report_failure("Far-memory bus active with nothing left to issue");

        if (dut0.props0.error_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            report_failure("Bus protocol assertions failed during the run");
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        report_failure($sformatf("TIMEOUT: run still going after %0d ns", WATCHDOG_NS));
    end

endmodule

`default_nettype wire

// ==== dv/cache_props.sv ====
//====================================================================
// Wishbone classic protocol assertions
//   - slave and far-memory ports of the cache top level
//   - ack within cycle/stb, stable request, single-cycle ack
//====================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_props import cache_pkg::*; (
    input wire              clk,
    input wire              reset,
    input wire              wb_cyc,
    input wire              wb_stb,
    input wire              wb_we,
    input wire [ADDR_W-1:0] wb_adr,
    input wire [DATA_W-1:0] wb_dat_w,
    input wire              wb_ack,
    input wire              fm_cyc,
    input wire              fm_stb,
    input wire              fm_we,
    input wire [ADDR_W-1:0] fm_adr,
    input wire [DATA_W-1:0] fm_dat_w,
    input wire              fm_ack
);

    // Read by the testbench at the end of the run
    int unsigned error_count = 0;

    // Ack only inside a cycle with strobe
    wb_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $error("slave ack outside cycle/stb");
            error_count++;
        end

    fm_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        fm_ack |-> (fm_cyc && fm_stb))
        else begin
            $error("far-memory ack outside cycle/stb");
            error_count++;
        end

    // Request held until acknowledged
    wb_req_stable: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_we) && $stable(wb_adr) && $stable(wb_dat_w)))
        else begin
            $error("slave request changed before ack");
            error_count++;
        end

    fm_req_stable: assert property (@(posedge clk) disable iff (reset)
        (fm_stb && !fm_ack) |=> (fm_stb && $stable(fm_we) && $stable(fm_adr) && $stable(fm_dat_w)))
        else begin
            $error("far-memory request changed before ack");
            error_count++;
        end

    // One ack per transfer
    wb_ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else begin
            $error("slave ack high two cycles in a row");
            error_count++;
        end

    fm_ack_single: assert property (@(posedge clk) disable iff (reset)
        fm_ack |=> !fm_ack)
        else begin
            $error("far-memory ack high two cycles in a row");
            error_count++;
        end

endmodule

bind cache_top cache_props props0 (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_ack,
    .fm_cyc, .fm_stb, .fm_we, .fm_adr, .fm_dat_w, .fm_ack
);

`default_nettype wire

// ==== logic/cache_top.sv ====
//====================================================================
// Set-associative write-through cache, top level
//   - Wishbone classic slave port and far-memory master port
//   - slave port, lookup pipe, arrays, request queue, bus master
//====================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; #(
    parameter int NUM_WAYS    = 4,
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                clk,
    input  wire                reset,
    // Slave side
    input  wire                wb_cyc,
    input  wire                wb_stb,
    input  wire                wb_we,
    input  wire [ADDR_W-1:0]   wb_adr,
    input  wire [DATA_W-1:0]   wb_dat_w,
    output logic [DATA_W-1:0]  wb_dat_r,
    output logic               wb_ack,
    // Far-memory side
    output logic               fm_cyc,
    output logic               fm_stb,
    output logic               fm_we,
    output logic [ADDR_W-1:0]  fm_adr,
    output logic [DATA_W-1:0]  fm_dat_w,
    input  wire [DATA_W-1:0]   fm_dat_r,
    input  wire                fm_ack
);

    lu_if                          lu0 ();
    array_if #(.NUM_WAYS(NUM_WAYS)) arr0 ();
    fm_req_if                      fmq0 ();

    // Queue to master and master to pipe
    logic              pop;
    logic              not_empty;
    t_fm_req           head;
    logic              fill_valid;
    logic [DATA_W-1:0] fill_data;

    cache_wb_slave u_slave (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_dat_r, .wb_ack, .lu(lu0.initiator)
    );

    cache_pipe #(.NUM_WAYS(NUM_WAYS)) u_pipe (
        .clk, .reset, .fill_valid, .fill_data,
        .lu(lu0.target), .arr(arr0.initiator), .fmq(fmq0.producer)
    );

    cache_arrays #(.NUM_WAYS(NUM_WAYS)) u_arrays (
        .clk, .reset, .arr(arr0.target)
    );

    cache_fm_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk, .reset, .pop, .fmq(fmq0.buffer), .not_empty, .head
    );

    cache_fm_master u_master (
        .clk, .reset, .not_empty, .head, .fm_dat_r, .fm_ack, .pop,
        .fm_cyc, .fm_stb, .fm_we, .fm_adr, .fm_dat_w, .fill_valid, .fill_data
    );

endmodule

`default_nettype wire

// ==== logic/cache_fm_master.sv ====
//====================================================================
// Far-memory Wishbone classic master
//   - presents the queue head and holds it until ack
//   - pops on ack, returns read data of a fill to the pipe
//====================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_fm_master import cache_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire                not_empty,
    input  var t_fm_req        head,
    input  wire [DATA_W-1:0]   fm_dat_r,
    input  wire                fm_ack,
    output logic               pop,
    output logic               fm_cyc,
    output logic               fm_stb,
    output logic               fm_we,
    output logic [ADDR_W-1:0]  fm_adr,
    output logic [DATA_W-1:0]  fm_dat_w,
    output logic               fill_valid,
    output logic [DATA_W-1:0]  fill_data
);

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_BUS  = 1'b1
    } t_state;

    t_state state;

    // Back to idle after each ack, so cyc drops for a cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (not_empty) state <= ST_BUS;
                ST_BUS:  if (fm_ack) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Head entry is stable until popped
    assign fm_cyc   = (state == ST_BUS);
    assign fm_stb   = (state == ST_BUS);
    assign fm_we    = (head.op == FM_WRITE);
    assign fm_adr   = head.addr.raw;
    assign fm_dat_w = head.data;
    assign pop      = (state == ST_BUS) && fm_ack;

    // Fill return, one cycle after the ack
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= pop && (head.op == FM_FILL);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            fill_data <= fm_dat_r;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_fm_queue.sv ====
//====================================================================
// Far-memory request queue
//   - circular FIFO of write-through and fill requests
//   - issue order kept, so a fill never passes an older write
//====================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_fm_queue import cache_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire       clk,
    input  wire       reset,
    input  wire       pop,
    fm_req_if.buffer  fmq,
    output logic      not_empty,
    output t_fm_req   head
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    t_fm_req          mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign fmq.full  = (count == CNT_W'(QUEUE_DEPTH));
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];
    assign do_push   = fmq.push && !fmq.full;
    assign do_pop    = pop && not_empty;

    // Entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= fmq.entry;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_arrays.sv ====
//====================================================================
// Cache storage
//   - tag, valid and data arrays per set and way, registered reads
//   - victim choice: lowest invalid way, else round-robin pointer
//====================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_arrays import cache_pkg::*; #(
    parameter int NUM_WAYS = 4
) (
    input  wire       clk,
    input  wire       reset,
    array_if.target   arr
);

    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    logic [TAG_W-1:0]    tag_mem  [NUM_SETS][NUM_WAYS];
    logic [DATA_W-1:0]   data_mem [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q  [NUM_SETS];
    logic [WAY_W-1:0]    rr_ptr   [NUM_SETS];
    logic [WAY_W-1:0]    victim_c;
    logic [SET_W-1:0]    wset;

    assign wset = arr.wr_addr.f.set;

    // Scan from the top so the lowest invalid way wins
    always_comb begin
        victim_c = rr_ptr[arr.rd_set];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[arr.rd_set][w]) begin
                victim_c = WAY_W'(w);
            end
        end
    end

    // Set read and data read, one cycle each
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            arr.tags[w] <= tag_mem[arr.rd_set][w];
        end
        arr.valid   <= valid_q[arr.rd_set];
        arr.victim  <= victim_c;
        arr.rd_data <= data_mem[arr.rd_dset][arr.rd_way];
    end

    // Data on write hit or install, tag on install only
    always_ff @(posedge clk) begin
        if (arr.wr_en || arr.inst_en) begin
            data_mem[wset][arr.wr_way] <= arr.wr_data;
        end
        if (arr.inst_en) begin
            tag_mem[wset][arr.wr_way] <= arr.wr_addr.f.tag;
        end
    end

    // Valid bits and round-robin pointers
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                rr_ptr[s]  <= '0;
            end
        end else if (arr.inst_en) begin
            valid_q[wset][arr.wr_way] <= 1'b1;
            // Pointer moves only when it picked the way in a full set
            if (&valid_q[wset] && (arr.wr_way == rr_ptr[wset])) begin
                rr_ptr[wset] <= (rr_ptr[wset] == WAY_W'(NUM_WAYS - 1)) ?
                                '0 : rr_ptr[wset] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_pipe.sv ====
//====================================================================
// Three-stage cache lookup pipeline
//   q1  set read
//   q2  tag compare and hit way encode, data read
//   q3  data write, far-memory push, fill wait and install, response
//====================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_pipe import cache_pkg::*; #(
    parameter int NUM_WAYS = 4
) (
    input  wire                clk,
    input  wire                reset,
    input  wire                fill_valid,
    input  wire [DATA_W-1:0]   fill_data,
    lu_if.target               lu,
    array_if.initiator         arr,
    fm_req_if.producer         fmq
);

    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    // Stage valids and payloads
    logic                v1, v2, v3;
    logic                q1_we, q2_we, q3_we;
    t_cache_addr         q1_addr, q2_addr, q3_addr;
    logic [DATA_W-1:0]   q1_wdata, q2_wdata, q3_wdata;
    // q2 compare results and q3 copies
    logic [NUM_WAYS-1:0] hit_vec;
    logic [WAY_W-1:0]    hit_way;
    logic                q3_hit;
    logic [WAY_W-1:0]    q3_way;
    logic [WAY_W-1:0]    q3_victim;
    // Miss handling
    logic                fill_pend;
    logic                accepted;
    logic                fill_done;

    //================================================================
    // q1
    //================================================================
    assign arr.rd_set = q1_addr.f.set;

    //================================================================
    // q2
    //================================================================
    // One-hot match over valid ways, then OR-encode to an index
    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = arr.valid[w] && (arr.tags[w] == q2_addr.f.tag);
            if (hit_vec[w]) begin
                hit_way = hit_way | WAY_W'(w);
            end
        end
    end

    assign arr.rd_dset = q2_addr.f.set;
    assign arr.rd_way  = hit_way;

    //================================================================
    // q3
    //================================================================
    // Writes always go through, read misses ask for a fill
    assign fmq.push  = v3 && !fill_pend && (q3_we || !q3_hit);
    assign fmq.entry = '{op: (q3_we ? FM_WRITE : FM_FILL), addr: q3_addr, data: q3_wdata};
    assign accepted  = fmq.push && !fmq.full;
    assign fill_done = fill_pend && fill_valid;

    // Read hit at once, write once queued, miss when the fill lands
    assign lu.rsp_valid = (v3 && !q3_we && q3_hit) || (accepted && q3_we) || fill_done;
    assign lu.rdata     = fill_pend ? fill_data : arr.rd_data;

    // Write hit updates the copy, fill installs into the victim
    assign arr.wr_en   = accepted && q3_we && q3_hit;
    assign arr.inst_en = fill_done;
    assign arr.wr_addr = q3_addr;
    assign arr.wr_way  = fill_pend ? q3_victim : q3_way;
    assign arr.wr_data = fill_pend ? fill_data : q3_wdata;

    // Stage control, q3 holds until its response
    always_ff @(posedge clk) begin
        if (reset) begin
            v1        <= 1'b0;
            v2        <= 1'b0;
            v3        <= 1'b0;
            fill_pend <= 1'b0;
        end else begin
            v1 <= lu.req_valid;
            v2 <= v1;
            v3 <= v2 || (v3 && !lu.rsp_valid);
            if (fill_done) begin
                fill_pend <= 1'b0;
            end else if (accepted && !q3_we) begin
                fill_pend <= 1'b1;
            end
        end
    end

    // Stage payloads
    always_ff @(posedge clk) begin
        if (lu.req_valid) begin
            q1_we    <= lu.we;
            q1_addr  <= lu.addr;
            q1_wdata <= lu.wdata;
        end
        q2_we    <= q1_we;
        q2_addr  <= q1_addr;
        q2_wdata <= q1_wdata;
        if (!v3 || lu.rsp_valid) begin
            q3_we     <= q2_we;
            q3_addr   <= q2_addr;
            q3_wdata  <= q2_wdata;
            q3_hit    <= |hit_vec;
            q3_way    <= hit_way;
            q3_victim <= arr.victim;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_wb_slave.sv ====
//====================================================================
// Wishbone classic slave port
//   - one cycle/stb pair becomes one lookup request
//   - lookup response returns as read data and a one-cycle ack
//====================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_wb_slave import cache_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire                wb_cyc,
    input  wire                wb_stb,
    input  wire                wb_we,
    input  wire [ADDR_W-1:0]   wb_adr,
    input  wire [DATA_W-1:0]   wb_dat_w,
    output logic [DATA_W-1:0]  wb_dat_r,
    output logic               wb_ack,
    lu_if.initiator            lu
);

    logic busy;
    logic start;

    // New transfer only while idle, busy stays up through the ack
    assign start = wb_cyc && wb_stb && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy         <= 1'b0;
            lu.req_valid <= 1'b0;
            wb_ack       <= 1'b0;
        end else begin
            lu.req_valid <= start;
            wb_ack       <= lu.rsp_valid;
            if (wb_ack) begin
                busy <= 1'b0;
            end else if (start) begin
                busy <= 1'b1;
            end
        end
    end

    // Request payload and returned read data
    always_ff @(posedge clk) begin
        if (start) begin
            lu.we       <= wb_we;
            lu.addr.raw <= wb_adr;
            lu.wdata    <= wb_dat_w;
        end
        if (lu.rsp_valid) begin
            wb_dat_r <= lu.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_ifs.sv ====
//====================================================================
// Internal cache interfaces
//   lu_if      slave port to lookup pipe
//   array_if   lookup pipe to tag, valid and data arrays
//   fm_req_if  lookup pipe to far-memory request queue
//====================================================================
`timescale 1ns/1ps
`default_nettype none

// One lookup request and its one-cycle response
interface lu_if import cache_pkg::*; ();
    logic              req_valid;
    logic              we;
    t_cache_addr       addr;
    logic [DATA_W-1:0] wdata;
    logic              rsp_valid;
    logic [DATA_W-1:0] rdata;

    modport initiator (output req_valid, we, addr, wdata, input rsp_valid, rdata);
    modport target    (input req_valid, we, addr, wdata, output rsp_valid, rdata);
endinterface

// Set read, data read, data write and fill install
interface array_if import cache_pkg::*; #(
    parameter int NUM_WAYS = 4
) ();
    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    // Set read in q1, answered in q2
    logic [SET_W-1:0]               rd_set;
    logic [NUM_WAYS-1:0][TAG_W-1:0] tags;
    logic [NUM_WAYS-1:0]            valid;
    logic [WAY_W-1:0]               victim;
    // Data read in q2, answered in q3
    logic [SET_W-1:0]               rd_dset;
    logic [WAY_W-1:0]               rd_way;
    logic [DATA_W-1:0]              rd_data;
    // Shared write port, install also sets tag and valid
    logic                           wr_en;
    logic                           inst_en;
    t_cache_addr                    wr_addr;
    logic [WAY_W-1:0]               wr_way;
    logic [DATA_W-1:0]              wr_data;

    modport initiator (
        output rd_set, rd_dset, rd_way, wr_en, inst_en, wr_addr, wr_way, wr_data,
        input  tags, valid, victim, rd_data
    );
    modport target (
        input  rd_set, rd_dset, rd_way, wr_en, inst_en, wr_addr, wr_way, wr_data,
        output tags, valid, victim, rd_data
    );
endinterface

// Request push with queue back-pressure
interface fm_req_if import cache_pkg::*; ();
    logic    push;
    t_fm_req entry;
    logic    full;

    modport producer (output push, entry, input full);
    modport buffer   (input push, entry, output full);
endinterface

`default_nettype wire

// ==== logic/cache_pkg.sv ====
//====================================================================
// Shared cache definitions
//   - address, data, set and tag widths
//   - word address union with a raw view and a tag/set view
//   - far-memory opcode and request queue entry
//====================================================================
`default_nettype none

package cache_pkg;

    // Word address and data widths
    localparam int ADDR_W   = 16;
    localparam int DATA_W   = 32;

    // Sixteen sets, tag takes the rest of the address
    localparam int SET_W    = 4;
    localparam int TAG_W    = ADDR_W - SET_W;
    localparam int NUM_SETS = 1 << SET_W;

    // One word address, raw for the bus side, split for lookup
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0] tag;
            logic [SET_W-1:0] set;
        } f;
    } t_cache_addr;

    // Far-memory operation
    typedef enum logic {
        FM_WRITE = 1'b0,
        FM_FILL  = 1'b1
    } t_fm_op;

    // One request queue entry
    typedef struct packed {
        t_fm_op            op;
        t_cache_addr       addr;
        logic [DATA_W-1:0] data;
    } t_fm_req;

endpackage

`default_nettype wire
